// File: project.f
oam_dma_pkg.sv
work_ram.sv
oam_ram.sv
byte_fifo.sv
dma_source_reader.sv
oam_writer.sv
apb_dma_regs.sv
oam_dma_top.sv
oam_dma_properties.sv
tb_oam_dma.sv

// File: Bender.yml
package:
  name: oam_dma

sources:
  - oam_dma_pkg.sv
  - work_ram.sv
  - oam_ram.sv
  - byte_fifo.sv
  - dma_source_reader.sv
  - oam_writer.sv
  - apb_dma_regs.sv
  - oam_dma_top.sv
  - target: test
    files:
      - oam_dma_properties.sv
      - tb_oam_dma.sv

// File: tb_oam_dma.sv
`timescale 1ns/1ns
`default_nettype none

module tb_oam_dma import oam_dma_pkg::*; ();

  localparam int clk_period      = 4;
  localparam int reset_cycles    = 10;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 2000;
  localparam int watchdog_time   = num_tests * cycles_per_test * clk_period;
  localparam int first_page      = int'(wram_base) / 256;
  localparam int page_count      = wram_bytes / 256;

  logic  clk;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  byte_t pwdata;
  byte_t prdata;
  logic  pready;
  logic  pslverr;
  logic  dma_active;

  // shadow of every byte written to work RAM
  byte_t shadow [wram_bytes];

  string name_q [$];
  byte_t exp_q [$];
  byte_t act_q [$];
  int    pending = 0;
  int    error_count = 0;
  int    check_count = 0;
  int    test_count = 0;
  int    test_start_errors = 0;
  string test_name = "";

  oam_dma_top i_oam_dma_top (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .dma_active (dma_active)
  );

  always #(clk_period / 2) clk = ~clk;

  // ==============================
  // reference model
  // ==============================
  function automatic byte_t expected_oam(byte_t page, int i);
    int pg;
    pg = int'(page);
    if (pg >= first_page && pg < first_page + page_count) begin
      return shadow[(pg - first_page) * 256 + i];
    end
    return unmapped_data;
  endfunction

  // hand a result to the compare process
  task automatic expect_value(input string what, input byte_t exp, input byte_t act);
    name_q.push_back($sformatf("%s %s", test_name, what));
    exp_q.push_back(exp);
    act_q.push_back(act);
    pending++;
  endtask

  task automatic expect_flag(input string what, input logic exp, input logic act);
    expect_value(what, {7'b0, exp}, {7'b0, act});
  endtask

  // ==============================
  // APB master
  // ==============================
  task automatic apb_access(input logic write, input addr_t addr, input byte_t wdata,
                            output byte_t rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // sample mid access phase
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    // no wait states on this slave
    expect_flag("pready", 1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input byte_t data, output logic err);
    byte_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input addr_t addr, output byte_t data, output logic err);
    apb_access(1'b0, addr, 8'h00, data, err);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    wait (pending == 0);
    test_count++;
    if (error_count == test_start_errors) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, error_count - test_start_errors);
    end
  endtask

  task automatic wait_transfer_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (dma_active && cycles < cycles_per_test) begin
      @(negedge clk);
      cycles++;
    end
    if (dma_active) begin
      $display("%s: DMA transfer still active after %0d cycles", test_name, cycles_per_test);
      error_count++;
    end
  endtask

  task automatic fill_page(input byte_t page);
    byte_t data;
    logic  err;
    for (int i = 0; i < oam_bytes; i++) begin
      data = byte_t'($urandom);
      shadow[(int'(page) - first_page) * 256 + i] = data;
      apb_write({page, 8'(i)}, data, err);
    end
  endtask

  task automatic check_oam_table(input byte_t page);
    byte_t data;
    logic  err;
    for (int i = 0; i < oam_bytes; i++) begin
      apb_read(oam_base + addr_t'(i), data, err);
      expect_value($sformatf("oam[%0d]", i), expected_oam(page, i), data);
      expect_flag($sformatf("oam[%0d] pslverr", i), 1'b0, err);
    end
  endtask

  // compare process
  initial begin
    string name;
    byte_t exp;
    byte_t act;
    forever begin
      wait (act_q.size() > 0);
      name = name_q.pop_front();
      exp  = exp_q.pop_front();
      act  = act_q.pop_front();
      check_count++;
      assert (act === exp) else begin
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        error_count++;
      end
      pending--;
    end
  end

  initial begin
    #(watchdog_time);
    $display("watchdog: run did not finish within %0d ns, stopping", watchdog_time);
    $display("=== FAIL ===");
    $finish;
  end

  // ==============================
  // tests
  // ==============================
  initial begin
    byte_t data;
    logic  err;
    void'($urandom(32'h86bcbf9d));
    clk     = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset_state");
    @(negedge clk);
    expect_flag("dma_active", 1'b0, dma_active);
    apb_read(dma_reg_addr, data, err);
    expect_value("dma register", 8'h00, data);
    expect_flag("pslverr", 1'b0, err);
    end_test();

    begin_test("register_readback");
    apb_write(dma_reg_addr, 8'hC3, err);
    expect_flag("pslverr on start", 1'b0, err);
    wait_transfer_done();
    apb_read(dma_reg_addr, data, err);
    expect_value("dma register", 8'hC3, data);
    end_test();

    begin_test("full_transfer");
    fill_page(8'hD1);
    apb_write(dma_reg_addr, 8'hD1, err);
    wait_transfer_done();
    check_oam_table(8'hD1);
    end_test();

    begin_test("out_of_range_page");
    apb_write(dma_reg_addr, 8'h80, err);
    wait_transfer_done();
    check_oam_table(8'h80);
    end_test();

    // all three accesses land while the copy is running
    begin_test("conflict_rule");
    apb_write(dma_reg_addr, 8'hD1, err);
    apb_write(dma_reg_addr, 8'h80, err);
    expect_flag("pslverr on register write", 1'b1, err);
    apb_write(16'hD105, ~expected_oam(8'hD1, 5), err);
    expect_flag("pslverr on work RAM write", 1'b1, err);
    apb_read(oam_base, data, err);
    expect_flag("pslverr on OAM read", 1'b1, err);
    expect_value("refused OAM read data", unmapped_data, data);
    wait_transfer_done();
    apb_read(dma_reg_addr, data, err);
    expect_value("dma register", 8'hD1, data);
    check_oam_table(8'hD1);
    apb_read(16'hD105, data, err);
    expect_value("work RAM byte D105", expected_oam(8'hD1, 5), data);
    end_test();

    begin_test("unmapped_read");
    apb_read(16'h8000, data, err);
    expect_value("data", unmapped_data, data);
    expect_flag("pslverr", 1'b0, err);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: oam_dma_properties.sv
`timescale 1ns/1ns
`default_nettype none

module oam_dma_properties import oam_dma_pkg::*; (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        penable,
  input wire logic        pready,
  input wire logic        push,
  input wire fifo_count_t fifo_count,
  input wire logic        done,
  input wire logic        dma_active
);

  // ==============================
  // APB and FIFO rules
  // ==============================

  // no wait states
  a_pready_in_access: assert property (@(posedge clk) disable iff (reset)
    penable |-> pready)
    else $error("pready low in the access phase");

  // the reader never pushes into a full FIFO
  a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    push |-> (fifo_count != fifo_count_t'(fifo_depth)))
    else $error("push while the FIFO is full");

  a_done_clears_active: assert property (@(posedge clk) disable iff (reset)
    done |=> !dma_active)
    else $error("dma_active still high after done");

endmodule

bind oam_dma_top oam_dma_properties i_oam_dma_properties (
  .clk        (clk),
  .reset      (reset),
  .penable    (penable),
  .pready     (pready),
  .push       (push),
  .fifo_count (fifo_count),
  .done       (done),
  .dma_active (dma_active)
);

`default_nettype wire

// File: oam_dma_top.sv
`timescale 1ns/1ns
`default_nettype none

module oam_dma_top import oam_dma_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  byte_t pwdata,
  output byte_t prdata,
  output logic  pready,
  output logic  pslverr,
  output logic  dma_active
);

  logic        start;
  byte_t       src_page;
  logic        done;
  byte_t       oam_rdata;
  oam_index_t  oam_raddr;
  byte_t       wram_rdata;
  logic        cpu_wram_we;
  logic        cpu_wram_re;
  addr_t       cpu_wram_addr;
  byte_t       cpu_wram_wdata;
  logic        rd_en;
  addr_t       rd_addr;
  logic        push;
  byte_t       push_data;
  logic        pop;
  byte_t       fifo_head;
  logic        fifo_empty;
  fifo_count_t fifo_count;
  logic        oam_we;
  oam_index_t  oam_waddr;
  byte_t       oam_wdata;

  // ==============================
  // CPU side
  // ==============================
  apb_dma_regs i_apb_dma_regs (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .done       (done),
    .oam_rdata  (oam_rdata),
    .wram_rdata (wram_rdata),
    .dma_active (dma_active),
    .start      (start),
    .src_page   (src_page),
    .oam_raddr  (oam_raddr),
    .wram_we    (cpu_wram_we),
    .wram_addr  (cpu_wram_addr),
    .wram_wdata (cpu_wram_wdata),
    .wram_re    (cpu_wram_re)
  );

  work_ram i_work_ram (
    .clk       (clk),
    .dma_re    (rd_en),
    .dma_addr  (rd_addr),
    .cpu_we    (cpu_wram_we),
    .cpu_re    (cpu_wram_re),
    .cpu_addr  (cpu_wram_addr),
    .cpu_wdata (cpu_wram_wdata),
    .rdata     (wram_rdata)
  );

  // ==============================
  // DMA pipeline
  // ==============================
  dma_source_reader i_dma_source_reader (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .src_page   (src_page),
    .fifo_count (fifo_count),
    .rd_data    (wram_rdata),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .push       (push),
    .push_data  (push_data)
  );

  byte_fifo i_byte_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

  oam_writer i_oam_writer (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .empty     (fifo_empty),
    .head      (fifo_head),
    .pop       (pop),
    .oam_we    (oam_we),
    .oam_waddr (oam_waddr),
    .oam_wdata (oam_wdata),
    .done      (done)
  );

  oam_ram i_oam_ram (
    .clk   (clk),
    .we    (oam_we),
    .waddr (oam_waddr),
    .wdata (oam_wdata),
    .raddr (oam_raddr),
    .rdata (oam_rdata)
  );

endmodule

`default_nettype wire

// File: apb_dma_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_dma_regs import oam_dma_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  addr_t      paddr,
  input  byte_t      pwdata,
  output byte_t      prdata,
  output logic       pready,
  output logic       pslverr,
  input  logic       done,
  input  byte_t      oam_rdata,
  input  byte_t      wram_rdata,
  output logic       dma_active,
  output logic       start,
  output byte_t      src_page,
  output oam_index_t oam_raddr,
  output logic       wram_we,
  output addr_t      wram_addr,
  output byte_t      wram_wdata,
  output logic       wram_re
);

  logic sel_reg;
  logic sel_wram;
  logic sel_oam;
  logic setup;
  logic access;
  logic blocked;

  // ==============================
  // address decode
  // ==============================
  assign sel_reg  = (paddr == dma_reg_addr);
  assign sel_wram = in_wram(paddr);
  assign sel_oam  = in_oam(paddr);
  assign setup    = psel && !penable;
  assign access   = psel && penable;

  // mapped windows are locked while the engine owns the RAMs
  assign blocked = dma_active && (sel_reg || sel_wram || sel_oam);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access && blocked;

  // work RAM is read in setup so the byte is ready in the access phase
  assign wram_addr  = paddr;
  assign wram_wdata = pwdata;
  assign wram_re    = setup && !pwrite && sel_wram && !dma_active;
  assign wram_we    = access && pwrite && sel_wram && !blocked;

  assign oam_raddr = oam_offset(paddr);

  always_comb begin
    if (blocked) begin
      prdata = unmapped_data;
    end else if (sel_reg) begin
      prdata = src_page;
    end else if (sel_wram) begin
      prdata = wram_rdata;
    end else if (sel_oam) begin
      prdata = oam_rdata;
    end else begin
      prdata = unmapped_data;
    end
  end

  // ==============================
  // DMA register and active flag
  // ==============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      src_page   <= '0;
      dma_active <= 1'b0;
      start      <= 1'b0;
    end else begin
      start <= 1'b0;
      if (access && pwrite && sel_reg && !blocked) begin
        src_page   <= pwdata;
        dma_active <= 1'b1;
        start      <= 1'b1;
      end else if (done) begin
        dma_active <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: oam_writer.sv
`timescale 1ns/1ns
`default_nettype none

module oam_writer import oam_dma_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       empty,
  input  byte_t      head,
  output logic       pop,
  output logic       oam_we,
  output oam_index_t oam_waddr,
  output byte_t      oam_wdata,
  output logic       done
);

  oam_index_t index;

  // drain whenever a byte is waiting
  assign pop       = !empty;
  assign oam_we    = pop;
  assign oam_waddr = index;
  assign oam_wdata = head;

  // final byte of the OAM table
  assign done = pop && (index == oam_index_t'(oam_bytes - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      index <= '0;
    end else if (start) begin
      index <= '0;
    end else if (pop) begin
      index <= index + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: dma_source_reader.sv
`timescale 1ns/1ns
`default_nettype none

module dma_source_reader import oam_dma_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  byte_t       src_page,
  input  fifo_count_t fifo_count,
  input  byte_t       rd_data,
  output logic        rd_en,
  output addr_t       rd_addr,
  output logic        push,
  output byte_t       push_data
);

  logic       busy;
  oam_index_t req_index;
  logic       in_flight;
  logic       has_room;

  // fifo fill plus the byte still coming back from the RAM
  assign has_room = (fifo_count + fifo_count_t'(in_flight)) < fifo_count_t'(fifo_depth);

  assign rd_en   = busy && has_room;
  assign rd_addr = {src_page, req_index};

  // RAM answers one cycle after the request
  assign push      = in_flight;
  assign push_data = rd_data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy      <= 1'b0;
      req_index <= '0;
      in_flight <= 1'b0;
    end else begin
      in_flight <= rd_en;
      if (start) begin
        busy      <= 1'b1;
        req_index <= '0;
      end else if (rd_en) begin
        req_index <= req_index + 1'b1;
        // last request of the page
        if (req_index == oam_index_t'(oam_bytes - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import oam_dma_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  byte_t       push_data,
  input  logic        pop,
  output byte_t       head,
  output logic        empty,
  output fifo_count_t count
);

  byte_t     mem [fifo_depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic      do_pop;

  assign empty  = (count == '0);
  assign head   = mem[rd_ptr];
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: oam_ram.sv
`timescale 1ns/1ns
`default_nettype none

module oam_ram import oam_dma_pkg::*; (
  input  logic       clk,
  input  logic       we,
  input  oam_index_t waddr,
  input  byte_t      wdata,
  input  oam_index_t raddr,
  output byte_t      rdata
);

  byte_t mem [oam_bytes];

  always_ff @(posedge clk) begin
    if (we && (waddr < oam_index_t'(oam_bytes))) begin
      mem[waddr] <= wdata;
    end
  end

  // index 160..255 has no storage behind it
  assign rdata = (raddr < oam_index_t'(oam_bytes)) ? mem[raddr] : unmapped_data;

endmodule

`default_nettype wire

// File: work_ram.sv
`timescale 1ns/1ns
`default_nettype none

module work_ram import oam_dma_pkg::*; (
  input  logic  clk,
  input  logic  dma_re,
  input  addr_t dma_addr,
  input  logic  cpu_we,
  input  logic  cpu_re,
  input  addr_t cpu_addr,
  input  byte_t cpu_wdata,
  output byte_t rdata
);

  byte_t      mem [wram_bytes];
  addr_t      port_addr;
  logic       port_we;
  logic       port_re;
  logic       hit;
  wram_addr_t offset;

  // ==============================
  // port mux, DMA first
  // ==============================
  always_comb begin
    if (dma_re) begin
      port_addr = dma_addr;
      port_we   = 1'b0;
      port_re   = 1'b1;
    end else begin
      port_addr = cpu_addr;
      port_we   = cpu_we;
      port_re   = cpu_re;
    end
  end

  assign hit    = in_wram(port_addr);
  assign offset = wram_offset(port_addr);

  always_ff @(posedge clk) begin
    if (port_we && hit) begin
      mem[offset] <= cpu_wdata;
    end
    // pages outside C0..DF float high
    if (port_re) begin
      rdata <= hit ? mem[offset] : unmapped_data;
    end
  end

endmodule

`default_nettype wire

// File: oam_dma_pkg.sv
`default_nettype none

package oam_dma_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [7:0] oam_index_t;

  // ==============================
  // memory map
  // ==============================
  localparam addr_t dma_reg_addr = 16'hFF46;
  localparam addr_t oam_base = 16'hFE00;
  localparam int oam_bytes = 160;
  localparam addr_t wram_base = 16'hC000;
  localparam int wram_bytes = 8192;

  // read value when nothing answers
  localparam byte_t unmapped_data = 8'hFF;

  // buffer between the reader and the OAM writer
  localparam int fifo_depth = 4;

  typedef logic [$clog2(wram_bytes)-1:0] wram_addr_t;
  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
  typedef logic [$clog2(fifo_depth+1)-1:0] fifo_count_t;

  // offset wraps mod 2^16, so one compare covers both window edges
  function automatic logic in_wram(addr_t addr);
    addr_t offset;
    offset = addr - wram_base;
    return offset < addr_t'(wram_bytes);
  endfunction

  function automatic logic in_oam(addr_t addr);
    addr_t offset;
    offset = addr - oam_base;
    return offset < addr_t'(oam_bytes);
  endfunction

  function automatic wram_addr_t wram_offset(addr_t addr);
    return wram_addr_t'(addr - wram_base);
  endfunction

  function automatic oam_index_t oam_offset(addr_t addr);
    return oam_index_t'(addr - oam_base);
  endfunction

endpackage

`default_nettype wire
